// ==== Makefile ====
# Verilator build and run for the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
cache_pkg.sv
cache_lookup.sv
cache_resolve.sv
cache_subsystem.sv
tb_axi_mem.sv
tb_cache_asserts.sv
tb_cache_subsystem.sv

// ==== cache_lookup.sv ====
// Cache lookup stage
`timescale 1ns/1ps
`default_nettype none

module cache_lookup #(
   parameter int LINE_BITS = 6
) (
   input  wire logic                clk,
   input  wire logic                clear,
   input  wire logic                flush,
   input  wire logic                req_valid,
   input  wire cache_pkg::cpu_req_t req,
   input  wire logic                stall,
   input  wire cache_pkg::patch_t   patch,
   output logic                     req_ready,
   output logic                     stage_valid,
   output cache_pkg::lookup_t       stage
);

   // number of lines and the width of the tag kept per line
   localparam int ENTRIES = 2 ** LINE_BITS;
   localparam int TAG_W   = cache_pkg::LINE_ADDR_W - LINE_BITS;

   // word address split, from the top
   //   tag   addr[22 : LINE_BITS+2]
   //   index addr[LINE_BITS+1 : 2]
   //   word  addr[1 : 0]
   logic [TAG_W-1:0]       tag_mem [ENTRIES];
   cache_pkg::cache_line_u data_mem [ENTRIES];
   logic [ENTRIES-1:0]     valid_bits;

   logic                 flush_pend;
   logic                 flush_now;
   logic                 accept;
   logic [LINE_BITS-1:0] req_idx;
   logic [LINE_BITS-1:0] patch_idx;

   assign req_idx   = req.addr[LINE_BITS+1:2];
   assign patch_idx = patch.index[LINE_BITS-1:0];

   // a flush waits until resolve has no miss or write in hand,
   // otherwise a fill landing after the flush would leave a line valid
   assign flush_now = (flush | flush_pend) & ~stall;

   // no new request while resolve is busy or while the valid bits are wiped
   assign req_ready = ~stall & ~flush_now;
   assign accept    = req_valid & req_ready;

   // remember a flush that arrives while the pipeline is busy
   always_ff @(posedge clk or posedge clear) begin
      if (clear) begin
         flush_pend <= 1'b0;
      end else begin
         flush_pend <= (flush | flush_pend) & ~flush_now;
      end
   end

   // stage_valid marks a request sitting in the pipeline register
   always_ff @(posedge clk or posedge clear) begin
      if (clear) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= accept;
      end
   end

   // capture the request together with everything stored at its index
   // resolve does the tag compare one cycle later
   always_ff @(posedge clk) begin
      if (accept) begin
         stage.req   <= req;
         stage.tag   <= {tag_mem[req_idx], {LINE_BITS{1'b0}}};
         stage.valid <= valid_bits[req_idx];
         stage.line  <= data_mem[req_idx];
      end
   end

   // valid bits are the only array state that clear and flush touch
   always_ff @(posedge clk or posedge clear) begin
      if (clear) begin
         valid_bits <= '0;
      end else if (flush_now) begin
         valid_bits <= '0;
      end else if (patch.store) begin
         // a completed fill makes its line valid
         valid_bits[patch_idx] <= 1'b1;
      end
   end

   // tag and data arrays
   always_ff @(posedge clk) begin
      if (patch.store) begin
         // whole line arrives from memory, tag comes from the top of the line address
         tag_mem[patch_idx]  <= patch.tag[cache_pkg::LINE_ADDR_W-1:LINE_BITS];
         data_mem[patch_idx] <= patch.data;
      end else if (patch.patch) begin
         // write hit, tag and valid stay as they are
         for (int b = 0; b < cache_pkg::LINE_W / 8; b++) begin
            if (patch.byte_en[b]) begin
               data_mem[patch_idx].bytes[b] <= patch.data.bytes[b];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// Cache shared types
`default_nettype none

package cache_pkg;

   // the cpu addresses 16-bit words, so 23 bits cover 16 MB
   localparam int ADDR_W = 23;

   // a line holds four words, which leaves 21 bits of line address
   localparam int LINE_ADDR_W = ADDR_W - 2;

   // width of the memory-side AXI4-Lite byte address
   localparam int AXI_ADDR_W = 32;

   // one cache line is moved as a single 64-bit beat
   localparam int LINE_W = 64;

   typedef logic [ADDR_W-1:0] word_addr_t;

   // cpu request, ds[1] enables bits 7..0 and ds[0] enables bits 15..8
   typedef struct packed {
      logic       write;
      word_addr_t addr;
      logic [1:0] ds;
      logic [15:0] wdata;
   } cpu_req_t;

   // cpu response word, qualified by a separate rsp_valid
   typedef struct packed {
      logic [15:0] rdata;
   } cpu_rsp_t;

   // the read path picks a word, the write patch path picks bytes
   // byte 2k is the low byte of word k
   typedef union packed {
      logic [3:0][15:0] words;
      logic [7:0][7:0]  bytes;
   } cache_line_u;

   // AXI4-Lite channel payloads, valid and ready travel as separate bits
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
   } axi_ar_t;

   typedef struct packed {
      logic [LINE_W-1:0] data;
   } axi_r_t;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
   } axi_aw_t;

   typedef struct packed {
      logic [LINE_W-1:0]   data;
      logic [LINE_W/8-1:0] strb;
   } axi_w_t;

   // register between lookup and resolve
   // the tag field is sized for the smallest cache, only its upper bits are meaningful
   typedef struct packed {
      cpu_req_t               req;
      logic [LINE_ADDR_W-1:0] tag;
      logic                   valid;
      cache_line_u            line;
   } lookup_t;

   // line store or byte patch sent back from resolve into the arrays
   typedef struct packed {
      logic                   store;
      logic                   patch;
      logic [LINE_ADDR_W-1:0] index;
      logic [LINE_ADDR_W-1:0] tag;
      cache_line_u            data;
      logic [LINE_W/8-1:0]    byte_en;
   } patch_t;

endpackage

`default_nettype wire

// ==== cache_resolve.sv ====
// Cache resolve stage
`timescale 1ns/1ps
`default_nettype none

module cache_resolve #(
   parameter int LINE_BITS = 6
) (
   input  wire logic               clk,
   input  wire logic               clear,
   input  wire logic               stage_valid,
   input  wire cache_pkg::lookup_t stage,
   input  wire logic               ar_ready,
   input  wire logic               r_valid,
   input  wire cache_pkg::axi_r_t  r,
   input  wire logic               aw_ready,
   input  wire logic               w_ready,
   input  wire logic               b_valid,
   output logic                    stall,
   output cache_pkg::patch_t       patch,
   output logic                    rsp_valid,
   output cache_pkg::cpu_rsp_t     rsp,
   output logic                    ar_valid,
   output cache_pkg::axi_ar_t      ar,
   output logic                    r_ready,
   output logic                    aw_valid,
   output cache_pkg::axi_aw_t      aw,
   output logic                    w_valid,
   output cache_pkg::axi_w_t       w,
   output logic                    b_ready
);

   localparam int A_HI = cache_pkg::ADDR_W - 1;
   localparam int T_HI = cache_pkg::LINE_ADDR_W - 1;

   // idle also covers read hits, which finish in a single cycle
   typedef enum logic [1:0] {
      S_IDLE,
      S_FILL,
      S_WRITE
   } state_t;

   state_t                         state;
   cache_pkg::cpu_req_t            req_q;
   logic                           hit_q;
   logic                           hit;
   logic                           needs_mem;
   logic                           take;
   logic                           r_fire;
   logic                           b_fire;
   logic [cache_pkg::AXI_ADDR_W-1:0] line_byte_addr;
   cache_pkg::cache_line_u         fill_line;
   cache_pkg::cache_line_u         w_line;
   logic [cache_pkg::LINE_W/8-1:0] byte_en;

   // tag compare on the entry that lookup registered
   assign hit = stage.valid &&
                (stage.tag[T_HI:LINE_BITS] == stage.req.addr[A_HI:LINE_BITS+2]);

   // misses and all writes go to memory and hold the pipeline
   assign needs_mem = stage_valid & (stage.req.write | ~hit);
   assign stall     = (state != S_IDLE) | needs_mem;

   // resolve takes a new request only from idle
   assign take = (state == S_IDLE) & stage_valid;

   // the cpu waits for each memory transaction, so ready tracks the state
   assign r_ready = (state == S_FILL);
   assign b_ready = (state == S_WRITE);
   assign r_fire  = r_valid & r_ready;
   assign b_fire  = b_valid & b_ready;

   // fill and write-through both address the aligned 8-byte line
   assign line_byte_addr = {{(cache_pkg::AXI_ADDR_W - cache_pkg::LINE_ADDR_W - 3){1'b0}},
                            req_q.addr[A_HI:2], 3'b000};

   assign fill_line = r.data;

   // put the write word in its own lane and set two strobe bits from ds
   always_comb begin
      w_line  = '0;
      byte_en = '0;
      w_line.words[req_q.addr[1:0]]   = req_q.wdata;
      byte_en[{req_q.addr[1:0], 1'b0}] = req_q.ds[1];
      byte_en[{req_q.addr[1:0], 1'b1}] = req_q.ds[0];
   end

   // the payload comes from req_q, so it stays put while valid waits for ready
   assign ar.addr = line_byte_addr;
   assign aw.addr = line_byte_addr;
   assign w.data  = w_line;
   assign w.strb  = byte_en;

   // fills and write hits go back to lookup on the handshake edge
   always_comb begin
      patch         = '0;
      patch.store   = r_fire;
      patch.patch   = b_fire & hit_q;
      patch.index[LINE_BITS-1:0] = req_q.addr[LINE_BITS+1:2];
      patch.tag     = req_q.addr[A_HI:2];
      patch.data    = r_fire ? fill_line : w_line;
      patch.byte_en = byte_en;
   end

   // control FSM and AXI valids
   always_ff @(posedge clk or posedge clear) begin
      if (clear) begin
         state     <= S_IDLE;
         hit_q     <= 1'b0;
         rsp_valid <= 1'b0;
         ar_valid  <= 1'b0;
         aw_valid  <= 1'b0;
         w_valid   <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state)
            S_IDLE: begin
               if (take) begin
                  if (stage.req.write) begin
                     // AW and W go up together and drop on their own handshakes
                     state    <= S_WRITE;
                     hit_q    <= hit;
                     aw_valid <= 1'b1;
                     w_valid  <= 1'b1;
                  end else if (!hit) begin
                     state    <= S_FILL;
                     ar_valid <= 1'b1;
                  end else begin
                     rsp_valid <= 1'b1;
                  end
               end
            end
            S_FILL: begin
               if (ar_ready) begin
                  ar_valid <= 1'b0;
               end
               if (r_fire) begin
                  state     <= S_IDLE;
                  rsp_valid <= 1'b1;
               end
            end
            S_WRITE: begin
               if (aw_ready) begin
                  aw_valid <= 1'b0;
               end
               if (w_ready) begin
                  w_valid <= 1'b0;
               end
               if (b_fire) begin
                  state     <= S_IDLE;
                  rsp_valid <= 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // request copy and response word
   always_ff @(posedge clk) begin
      if (take) begin
         req_q <= stage.req;
      end
      if (take && !stage.req.write && hit) begin
         rsp.rdata <= stage.line.words[stage.req.addr[1:0]];
      end else if (r_fire) begin
         // the missed word is taken straight from the fetched line
         rsp.rdata <= fill_line.words[req_q.addr[1:0]];
      end else if (b_fire) begin
         rsp.rdata <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== cache_subsystem.sv ====
// Cache subsystem top
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem #(
   parameter int LINE_BITS = 6
) (
   input  wire logic                clk,
   input  wire logic                clear,
   input  wire logic                flush,
   // cpu request and response
   input  wire logic                req_valid,
   input  wire cache_pkg::cpu_req_t req,
   output logic                     req_ready,
   output logic                     rsp_valid,
   output cache_pkg::cpu_rsp_t      rsp,
   // AXI4-Lite master toward memory
   output logic                     ar_valid,
   output cache_pkg::axi_ar_t       ar,
   input  wire logic                ar_ready,
   input  wire logic                r_valid,
   input  wire cache_pkg::axi_r_t   r,
   output logic                     r_ready,
   output logic                     aw_valid,
   output cache_pkg::axi_aw_t       aw,
   input  wire logic                aw_ready,
   output logic                     w_valid,
   output cache_pkg::axi_w_t        w,
   input  wire logic                w_ready,
   input  wire logic                b_valid,
   output logic                     b_ready
);

   // pipeline register from lookup into resolve
   logic               stage_valid;
   cache_pkg::lookup_t stage;

   // feedback from resolve, stall holds new requests and patch updates the arrays
   logic               stall;
   cache_pkg::patch_t  patch;

   cache_lookup #(
      .LINE_BITS (LINE_BITS)
   ) cache_lookup_i (
      .clk         (clk),
      .clear       (clear),
      .flush       (flush),
      .req_valid   (req_valid),
      .req         (req),
      .stall       (stall),
      .patch       (patch),
      .req_ready   (req_ready),
      .stage_valid (stage_valid),
      .stage       (stage)
   );

   cache_resolve #(
      .LINE_BITS (LINE_BITS)
   ) cache_resolve_i (
      .clk         (clk),
      .clear       (clear),
      .stage_valid (stage_valid),
      .stage       (stage),
      .ar_ready    (ar_ready),
      .r_valid     (r_valid),
      .r           (r),
      .aw_ready    (aw_ready),
      .w_ready     (w_ready),
      .b_valid     (b_valid),
      .stall       (stall),
      .patch       (patch),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp),
      .ar_valid    (ar_valid),
      .ar          (ar),
      .r_ready     (r_ready),
      .aw_valid    (aw_valid),
      .aw          (aw),
      .w_valid     (w_valid),
      .w           (w),
      .b_ready     (b_ready)
   );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
// AXI4-Lite test memory
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
   input  wire logic               clk,
   input  wire logic               clear,
   input  wire logic               ar_valid,
   input  wire cache_pkg::axi_ar_t ar,
   output logic                    ar_ready,
   output logic                    r_valid,
   output cache_pkg::axi_r_t       r,
   input  wire logic               r_ready,
   input  wire logic               aw_valid,
   input  wire cache_pkg::axi_aw_t aw,
   output logic                    aw_ready,
   input  wire logic               w_valid,
   input  wire cache_pkg::axi_w_t  w,
   output logic                    w_ready,
   output logic                    b_valid,
   input  wire logic               b_ready
);

   // only bytes that were written are stored, the rest follow the fill rule
   logic [7:0]  mem [int unsigned];
   logic [31:0] lcg;
   logic [1:0]  delay;
   logic        armed;

   function automatic logic [7:0] byte_at(input int unsigned b);
      logic [31:0] p;
      p = b * 32'h3B;
      if (mem.exists(b)) begin
         return mem[b];
      end
      return p[7:0] ^ 8'h5A;
   endfunction

   always @(posedge clk or posedge clear) begin
      if (clear) begin
         ar_ready <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         r_valid  <= 1'b0;
         b_valid  <= 1'b0;
         r        <= '0;
         lcg      <= 32'h9686;
         delay    <= '0;
         armed    <= 1'b0;
      end else begin
         ar_ready <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         if (r_valid && r_ready) r_valid <= 1'b0;
         if (b_valid && b_ready) b_valid <= 1'b0;
         // one transaction at a time, the master never has two open
         if ((ar_valid || (aw_valid && w_valid)) && !ar_ready && !aw_ready &&
             !r_valid && !b_valid) begin
            if (!armed) begin
               // pick a fresh wait of 1 to 4 cycles
               armed <= 1'b1;
               delay <= lcg[17:16];
               lcg   <= lcg * 32'd1103515245 + 32'd12345;
            end else if (delay != 0) begin
               delay <= delay - 2'd1;
            end else begin
               armed <= 1'b0;
               if (ar_valid) begin
                  ar_ready <= 1'b1;
                  r_valid  <= 1'b1;
                  for (int i = 0; i < 8; i++) begin
                     r.data[8*i +: 8] <= byte_at({ar.addr[31:3], 3'b000} + i);
                  end
               end else begin
                  aw_ready <= 1'b1;
                  w_ready  <= 1'b1;
                  b_valid  <= 1'b1;
                  for (int i = 0; i < 8; i++) begin
                     if (w.strb[i]) mem[{aw.addr[31:3], 3'b000} + i] = w.data[8*i +: 8];
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_cache_asserts.sv ====
// Cache protocol assertions
`timescale 1ns/1ps
`default_nettype none

module tb_cache_asserts (
   input wire logic               clk,
   input wire logic               clear,
   input wire logic               req_valid,
   input wire logic               req_ready,
   input wire logic               rsp_valid,
   input wire logic               ar_valid,
   input wire logic               ar_ready,
   input wire cache_pkg::axi_ar_t ar,
   input wire logic               aw_valid,
   input wire logic               aw_ready,
   input wire cache_pkg::axi_aw_t aw
);

   // requests accepted but not yet answered
   int open_cnt;

   always @(posedge clk or posedge clear) begin
      if (clear) begin
         open_cnt <= 0;
      end else begin
         open_cnt <= open_cnt + int'(req_valid && req_ready) - int'(rsp_valid);
      end
   end

   // a waiting address holds still until the slave takes it
   ar_hold: assert property (@(posedge clk) disable iff (clear)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else $error("ARVALID dropped or AR address changed before ready");

   aw_hold: assert property (@(posedge clk) disable iff (clear)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else $error("AWVALID dropped or AW address changed before ready");

   // every response belongs to an earlier accepted request
   rsp_count: assert property (@(posedge clk) disable iff (clear)
      rsp_valid |-> open_cnt > 0)
      else $error("response without an open request");

   ready_after_clear: assert property (@(posedge clk) $fell(clear) |=> req_ready)
      else $error("req_ready low one cycle after clear released");

endmodule

bind cache_subsystem tb_cache_asserts tb_cache_asserts_i (
   .clk       (clk),
   .clear     (clear),
   .req_valid (req_valid),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid),
   .ar_valid  (ar_valid),
   .ar_ready  (ar_ready),
   .ar        (ar),
   .aw_valid  (aw_valid),
   .aw_ready  (aw_ready),
   .aw        (aw)
);

`default_nettype wire

// ==== tb_cache_subsystem.sv ====
// Cache subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;

   // requests over all tests: reset 5, write-through 9, write miss 2,
   // conflict 4, flush 5 and stream 68
   localparam int N_REQ = 93;
   localparam int LIMIT = 20 * N_REQ + 200;

   logic clk = 1'b0;
   logic clear, flush, req_valid, req_ready, rsp_valid;
   cache_pkg::cpu_req_t req;
   cache_pkg::cpu_rsp_t rsp;
   logic ar_valid, ar_ready, r_valid, r_ready;
   logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   cache_pkg::axi_ar_t ar;
   cache_pkg::axi_r_t  r;
   cache_pkg::axi_aw_t aw;
   cache_pkg::axi_w_t  w;

   // expected memory contents, bytes not written follow the fill rule
   logic [7:0] model [int unsigned];
   logic [31:0] rnd = 32'h9686;
   int errors = 0;
   int checks = 0;
   int ar_count = 0;
   int cycles = 0;
   // byte addresses of the latest read and write handshakes
   logic [31:0] ar_last = '0;
   logic [31:0] aw_last = '0;

   always #2 clk = ~clk;

   cache_subsystem #(.LINE_BITS(6)) cache_subsystem_i (.*);

   tb_axi_mem mem_i (.*);

   always @(posedge clk) begin
      if (!clear && ar_valid && ar_ready) begin
         ar_count <= ar_count + 1;
         ar_last  <= ar.addr;
      end
      if (!clear && aw_valid && aw_ready) begin
         aw_last <= aw.addr;
      end
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", LIMIT);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [7:0] model_byte(input int unsigned b);
      logic [31:0] p;
      p = b * 32'h3B;
      if (model.exists(b)) return model[b];
      return p[7:0] ^ 8'h5A;
   endfunction

   // word a keeps its low byte at byte 2a
   function automatic logic [15:0] model_word(input int unsigned a);
      return {model_byte(2 * a + 1), model_byte(2 * a)};
   endfunction

   task automatic check_val(input string name, input int exp, input int act);
      checks++;
      if (exp != act) begin
         errors++;
         $display("ERROR %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   // all tasks start on a rising edge and end on one
   task automatic cpu_access(input logic wr, input int unsigned a, input logic [1:0] ds,
                             input logic [15:0] wd, output logic [15:0] rd, output int lat);
      req_valid <= 1'b1;
      req <= '{write: wr, addr: a[22:0], ds: ds, wdata: wd};
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!rsp_valid);
      rd = rsp.rdata;
   endtask

   task automatic read_check(input string name, input int unsigned a, input int new_ars);
      logic [15:0] rd;
      int lat;
      int ar0;
      ar0 = ar_count;
      cpu_access(1'b0, a, 2'b00, 16'h0, rd, lat);
      check_val({name, " data"}, model_word(a), rd);
      check_val({name, " ar"}, new_ars, ar_count - ar0);
      // a fill reads the whole line from its 8-byte aligned byte address
      if (new_ars == 1) check_val({name, " ar addr"}, (a / 4) * 8, ar_last);
      if (new_ars == 0) check_val({name, " latency"}, 2, lat);
   endtask

   task automatic write_word(input string name, input int unsigned a, input logic [1:0] ds,
                             input logic [15:0] wd);
      logic [15:0] rd;
      int lat;
      int ar0;
      ar0 = ar_count;
      cpu_access(1'b1, a, ds, wd, rd, lat);
      check_val({name, " wr rsp"}, 0, rd);
      check_val({name, " wr ar"}, 0, ar_count - ar0);
      check_val({name, " wr addr"}, (a / 4) * 8, aw_last);
      if (ds[1]) model[2 * a] = wd[7:0];
      if (ds[0]) model[2 * a + 1] = wd[15:8];
   endtask

   task automatic test_reset_read();
      check_val("reset req_ready", 1, req_ready);
      check_val("reset valids", 0, {rsp_valid, ar_valid, aw_valid, w_valid, r_ready, b_ready});
      read_check("first read", 23'h123, 1);
      for (int k = 0; k < 4; k++) read_check("repeat read", 23'h120 + k, 0);
   endtask

   task automatic test_write_through();
      read_check("warm", 23'h340, 1);
      for (int d = 0; d < 4; d++) begin
         rnd = lcg_next(rnd);
         write_word("strobe", 23'h341 + (d % 3), d[1:0], rnd[23:8]);
         read_check("strobe rd", 23'h341 + (d % 3), 0);
      end
   endtask

   task automatic test_write_miss();
      write_word("wmiss", 23'h5A7, 2'b01, 16'hBEEF);
      read_check("wmiss rd", 23'h5A7, 1);
   endtask

   task automatic test_conflict();
      // same index, tags one apart
      for (int k = 0; k < 2; k++) begin
         read_check("conflict a", 23'h0810, 1);
         read_check("conflict b", 23'h0810 + (1 << 8), 1);
      end
   endtask

   task automatic test_flush();
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      check_val("flush ready", 0, req_ready);
      // memory under the patched line has to carry the write-through bytes
      read_check("flush a", 23'h341, 1);
      // the refilled line brings the other written words back from memory
      read_check("flush a2", 23'h342, 0);
      read_check("flush a3", 23'h343, 0);
      read_check("flush b", 23'h5A7, 1);
      read_check("flush c", 23'h0910, 1);
   endtask

   task automatic test_stream();
      logic [15:0] exp_q[$];
      int unsigned a;
      int sent;
      int got;
      int ar0;
      for (int k = 0; k < 4; k++) read_check("stream warm", 23'h2000 + 4 * k, 1);
      ar0 = ar_count;
      sent = 0;
      got = 0;
      rnd = lcg_next(rnd);
      a = 23'h2000 + rnd[19:16];
      req_valid <= 1'b1;
      req <= '{write: 1'b0, addr: a[22:0], ds: 2'b00, wdata: 16'h0};
      while (got < 64) begin
         @(posedge clk);
         if (req_valid && req_ready) begin
            exp_q.push_back(model_word(a));
            sent++;
            if (sent < 64) begin
               rnd = lcg_next(rnd);
               a = 23'h2000 + rnd[19:16];
               req <= '{write: 1'b0, addr: a[22:0], ds: 2'b00, wdata: 16'h0};
            end else begin
               req_valid <= 1'b0;
            end
         end
         if (rsp_valid) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("stream: a response arrived with no request waiting for one");
            end else begin
               check_val("stream data", exp_q.pop_front(), rsp.rdata);
            end
            got++;
         end
      end
      check_val("stream ar", 0, ar_count - ar0);
   endtask

   initial begin
      clear = 1'b1;
      flush = 1'b0;
      req_valid = 1'b0;
      req = '0;
      repeat (5) @(posedge clk);
      clear <= 1'b0;
      @(posedge clk);
      test_reset_read();
      test_write_through();
      test_write_miss();
      test_conflict();
      test_flush();
      test_stream();
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
